//--- hw/block_emitter.sv
`timescale 1ns/1ps

module block_emitter (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             blk_valid,
    input  logic [wbuf_pkg::block_width-1:0] blk_data,
    input  logic [wbuf_pkg::brow_width-1:0]  blk_row,
    input  logic [wbuf_pkg::bcol_width-1:0]  blk_col,
    output logic                             block_valid,
    output logic [wbuf_pkg::block_width-1:0] block_data,
    output logic [wbuf_pkg::brow_width-1:0]  block_row,
    output logic [wbuf_pkg::bcol_width-1:0]  block_col,
    output logic                             slice_done,
    output logic                             slice_last,
    output logic                             buffer_done
);

    import wbuf_pkg::*;

    localparam logic [brow_width-1:0] last_brow = brow_width'(block_rows - 1);
    localparam logic [bcol_width-1:0] last_bcol = bcol_width'(col_groups - 1);

    logic row_end;
    logic col_end;

    assign row_end = blk_valid && (blk_row == last_brow);
    assign col_end = (blk_col == last_bcol);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            block_valid <= 1'b0;
            slice_done  <= 1'b0;
            slice_last  <= 1'b0;
        end else begin
            block_valid <= blk_valid;
            // Markers drop whenever no block is present
            slice_done  <= row_end;
            slice_last  <= row_end && col_end;
        end
    end

    always_ff @(posedge clk) begin
        block_data <= blk_data;
        block_row  <= blk_row;
        block_col  <= blk_col;
    end

    // Last slice closes the buffer
    assign buffer_done = slice_last;

endmodule

//--- hw/r2b_converter_w.sv
`timescale 1ns/1ps

module r2b_converter_w (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                full,
    input  logic [wbuf_pkg::row_width-1:0]      rdata0,
    input  logic [wbuf_pkg::row_width-1:0]      rdata1,
    output logic [wbuf_pkg::row_addr_width-1:0] raddr0,
    output logic [wbuf_pkg::row_addr_width-1:0] raddr1,
    output logic                                blk_valid,
    output logic [wbuf_pkg::block_width-1:0]    blk_data,
    output logic [wbuf_pkg::brow_width-1:0]     blk_row,
    output logic [wbuf_pkg::bcol_width-1:0]     blk_col,
    output logic                                scan_done
);

    import wbuf_pkg::*;

    localparam int scan_width = brow_width + bcol_width;
    localparam logic [scan_width-1:0] last_scan = scan_width'(block_rows * col_groups - 1);
    localparam logic [brow_width-1:0] last_brow = brow_width'(block_rows - 1);
    localparam logic [bcol_width-1:0] last_bcol = bcol_width'(col_groups - 1);

    logic [scan_width-1:0]  scan_cnt;
    logic                   scanning;
    logic                   issue;
    logic [brow_width-1:0]  scan_brow;
    logic [bcol_width-1:0]  scan_bcol;

    // Indices aligned with the memory read data
    logic                   iss_d1;
    logic [brow_width-1:0]  brow_d1;
    logic [bcol_width-1:0]  bcol_d1;

    logic [block_width-1:0] blk_asm;

    // Block row is the fast index, column group the slow one
    assign scan_brow = scan_cnt[brow_width-1:0];
    assign scan_bcol = scan_cnt[scan_width-1:brow_width];

    // First pair goes out in the same cycle as full
    assign issue = full || scanning;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            scan_cnt <= '0;
            scanning <= 1'b0;
        end else if (issue) begin
            scan_cnt <= scan_cnt + 1'b1;
            scanning <= (scan_cnt != last_scan);
        end
    end

    // Top and bottom row of the current block
    assign raddr0 = {scan_brow, 1'b0};
    assign raddr1 = {scan_brow, 1'b1};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            iss_d1 <= 1'b0;
        end else begin
            iss_d1 <= issue;
        end
    end

    always_ff @(posedge clk) begin
        brow_d1 <= scan_brow;
        bcol_d1 <= scan_bcol;
    end

    // Column groups run right to left; bottom row first in each column
    always_comb begin
        int base;
        base = (col_groups - 1 - int'(bcol_d1)) * block_size;
        blk_asm = '0;
        for (int j = 0; j < block_size; j++) begin
            for (int r = 0; r < block_size; r++) begin
                if (r == 0) begin
                    blk_asm[(j*block_size+r)*elem_width +: elem_width] =
                        rdata1[(base+j)*elem_width +: elem_width];
                end else begin
                    blk_asm[(j*block_size+r)*elem_width +: elem_width] =
                        rdata0[(base+j)*elem_width +: elem_width];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            blk_valid <= 1'b0;
            scan_done <= 1'b0;
        end else begin
            blk_valid <= iss_d1;
            // Lines up with the last block leaving the emitter
            scan_done <= blk_valid && (blk_row == last_brow) && (blk_col == last_bcol);
        end
    end

    always_ff @(posedge clk) begin
        blk_data <= blk_asm;
        blk_row  <= brow_d1;
        blk_col  <= bcol_d1;
    end

endmodule

//--- hw/ram_1w2r.sv
`timescale 1ns/1ps

module ram_1w2r #(
    parameter int data_width = 128,
    parameter int depth      = 8
) (
    input  logic                          clk,
    input  logic                          we,
    input  logic [$clog2(depth)-1:0]      waddr,
    input  logic [data_width-1:0]         wdata,
    input  logic [$clog2(depth)-1:0]      raddr0,
    input  logic [$clog2(depth)-1:0]      raddr1,
    output logic [data_width-1:0]         rdata0,
    output logic [data_width-1:0]         rdata1
);

    logic [data_width-1:0] mem [depth];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Both read ports registered, one cycle latency
    always_ff @(posedge clk) begin
        rdata0 <= mem[raddr0];
        rdata1 <= mem[raddr1];
    end

endmodule

//--- hw/row_loader.sv
`timescale 1ns/1ps

module row_loader (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               start,
    input  logic                               in_valid,
    input  logic [wbuf_pkg::row_width-1:0]     in_data,
    input  logic                               scan_done,
    output logic                               we,
    output logic [wbuf_pkg::row_addr_width-1:0] waddr,
    output logic [wbuf_pkg::row_width-1:0]     wdata,
    output logic                               full,
    output logic                               busy
);

    import wbuf_pkg::*;

    localparam logic [row_addr_width-1:0] last_row = row_addr_width'(num_rows - 1);

    typedef enum logic [1:0] {
        st_idle,
        st_fill,
        st_drain
    } state_t;

    state_t                    state;
    logic [row_addr_width-1:0] row_cnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= st_idle;
            row_cnt <= '0;
            we      <= 1'b0;
            full    <= 1'b0;
        end else begin
            we   <= 1'b0;
            // One cycle after the last row lands in memory
            full <= we && (waddr == last_row);
            case (state)
                st_idle: begin
                    if (start) begin
                        state   <= st_fill;
                        row_cnt <= '0;
                    end
                end
                st_fill: begin
                    if (in_valid) begin
                        we      <= 1'b1;
                        row_cnt <= row_cnt + 1'b1;
                        if (row_cnt == last_row) begin
                            state <= st_drain;
                        end
                    end
                end
                st_drain: begin
                    // Wait for the converter to finish the scan
                    if (scan_done) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_fill && in_valid) begin
            waddr <= row_cnt;
            wdata <= in_data;
        end
    end

    assign busy = (state != st_idle);

endmodule

//--- hw/wbuf_pkg.sv
package wbuf_pkg;

    // Matrix shape
    localparam int elem_width = 16;
    localparam int num_rows   = 8;
    localparam int num_cols   = 8;

    // Block shape, height fixed by the two read ports
    localparam int block_size = 2;
    localparam int chunk_size = block_size * block_size;

    // Derived widths
    localparam int row_width   = num_cols * elem_width;
    localparam int block_width = chunk_size * elem_width;

    // Block grid
    localparam int block_rows = num_rows / block_size;
    localparam int col_groups = num_cols / block_size;

    // Index widths
    localparam int row_addr_width = $clog2(num_rows);
    localparam int brow_width     = $clog2(block_rows);
    localparam int bcol_width     = $clog2(col_groups);

endpackage

//--- hw/weight_block_top.sv
`timescale 1ns/1ps

module weight_block_top (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             start,
    input  logic                             in_valid,
    input  logic [wbuf_pkg::row_width-1:0]   in_data,
    output logic                             busy,
    output logic                             block_valid,
    output logic [wbuf_pkg::block_width-1:0] block_data,
    output logic [wbuf_pkg::brow_width-1:0]  block_row,
    output logic [wbuf_pkg::bcol_width-1:0]  block_col,
    output logic                             slice_done,
    output logic                             slice_last,
    output logic                             buffer_done
);

    import wbuf_pkg::*;

    logic                      we;
    logic [row_addr_width-1:0] waddr;
    logic [row_width-1:0]      wdata;
    logic                      full;
    logic                      scan_done;
    logic [row_addr_width-1:0] raddr0;
    logic [row_addr_width-1:0] raddr1;
    logic [row_width-1:0]      rdata0;
    logic [row_width-1:0]      rdata1;
    logic                      blk_valid;
    logic [block_width-1:0]    blk_data;
    logic [brow_width-1:0]     blk_row;
    logic [bcol_width-1:0]     blk_col;

    row_loader loader_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .scan_done (scan_done),
        .we        (we),
        .waddr     (waddr),
        .wdata     (wdata),
        .full      (full),
        .busy      (busy)
    );

    ram_1w2r #(
        .data_width (row_width),
        .depth      (num_rows)
    ) ram_i (
        .clk    (clk),
        .we     (we),
        .waddr  (waddr),
        .wdata  (wdata),
        .raddr0 (raddr0),
        .raddr1 (raddr1),
        .rdata0 (rdata0),
        .rdata1 (rdata1)
    );

    r2b_converter_w conv_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .full      (full),
        .rdata0    (rdata0),
        .rdata1    (rdata1),
        .raddr0    (raddr0),
        .raddr1    (raddr1),
        .blk_valid (blk_valid),
        .blk_data  (blk_data),
        .blk_row   (blk_row),
        .blk_col   (blk_col),
        .scan_done (scan_done)
    );

    block_emitter emit_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .blk_valid   (blk_valid),
        .blk_data    (blk_data),
        .blk_row     (blk_row),
        .blk_col     (blk_col),
        .block_valid (block_valid),
        .block_data  (block_data),
        .block_row   (block_row),
        .block_col   (block_col),
        .slice_done  (slice_done),
        .slice_last  (slice_last),
        .buffer_done (buffer_done)
    );

endmodule

//--- list.f
hw/wbuf_pkg.sv
hw/ram_1w2r.sv
hw/row_loader.sv
hw/r2b_converter_w.sv
hw/block_emitter.sv
hw/weight_block_top.sv
verif/tb_weight_block.sv

//--- verif/tb_weight_block.sv
`timescale 1ns/1ps

module tb_weight_block;

    import wbuf_pkg::*;

    localparam int clk_period    = 10;
    localparam int reset_cycles  = 16;
    localparam int num_buffers   = 5;
    localparam int margin_cycles = 300;
    localparam int num_blocks    = block_rows * col_groups;

    logic                   clk;
    logic                   rst_n;
    logic                   start;
    logic                   in_valid;
    logic [row_width-1:0]   in_data;
    logic                   busy;
    logic                   block_valid;
    logic [block_width-1:0] block_data;
    logic [brow_width-1:0]  block_row;
    logic [bcol_width-1:0]  block_col;
    logic                   slice_done;
    logic                   slice_last;
    logic                   buffer_done;

    logic [row_width-1:0]   mat [num_rows];
    int                     exp_k [$];
    logic [block_width-1:0] exp_data [$];
    int                     seed = 76;
    int                     cyc = 0;
    int                     last_accept_cyc = 0;
    int                     block_count = 0;
    int                     buffer_count = 0;
    int                     fail_count = 0;

    weight_block_top dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .in_valid    (in_valid),
        .in_data     (in_data),
        .busy        (busy),
        .block_valid (block_valid),
        .block_data  (block_data),
        .block_row   (block_row),
        .block_col   (block_col),
        .slice_done  (slice_done),
        .slice_last  (slice_last),
        .buffer_done (buffer_done)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic stop_with_failure();
        fail_count++;
        $display("Some tests failed");
        $fatal(1, "Stopping at the first failure");
    endtask

    task automatic check_value(input string what, input logic [block_width-1:0] got,
                               input logic [block_width-1:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] %0t ns %s: got %h, expected %h", $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    // Expected block k straight from the stored matrix
    function automatic logic [block_width-1:0] expected_block(input int k);
        int c;
        int b;
        int base;
        logic [block_width-1:0] blk;
        c    = k / block_rows;
        b    = k % block_rows;
        base = (col_groups - 1 - c) * block_size;
        blk  = '0;
        for (int j = 0; j < block_size; j++) begin
            for (int r = 0; r < block_size; r++) begin
                blk[(j*2+r)*elem_width +: elem_width] =
                    mat[b*2+1-r][(base+j)*elem_width +: elem_width];
            end
        end
        return blk;
    endfunction

    always @(negedge clk) begin : block_monitor
        int k;
        logic [block_width-1:0] exp_blk;
        if (rst_n && block_valid) begin
            assert (exp_k.size() > 0) else begin
                $display("A block came out at %0t ns while none was expected", $time);
                stop_with_failure();
            end
            k       = exp_k.pop_front();
            exp_blk = exp_data.pop_front();
            check_value("block_data", block_data, exp_blk);
            check_value("block_row", block_row, k % block_rows);
            check_value("block_col", block_col, k / block_rows);
            check_value("slice_done", slice_done, (k % block_rows) == block_rows - 1);
            check_value("slice_last", slice_last, k == num_blocks - 1);
            check_value("buffer_done", buffer_done, k == num_blocks - 1);
            block_count++;
            if (buffer_done) begin
                buffer_count++;
            end
        end else if (rst_n) begin
            check_value("markers without block", {slice_done, slice_last, buffer_done}, 0);
        end
    end

    function automatic void fill_counting();
        for (int i = 0; i < num_rows; i++) begin
            for (int j = 0; j < num_cols; j++) begin
                mat[i][j*elem_width +: elem_width] = elem_width'(i * 256 + j);
            end
        end
    endfunction

    function automatic void fill_random();
        for (int i = 0; i < num_rows; i++) begin
            for (int w = 0; w < row_width / 32; w++) begin
                mat[i][w*32 +: 32] = $random(seed);
            end
        end
    endfunction

    // Start strobe, then one row per strobe with 0 to max_gap idle cycles before each
    task automatic load_matrix(input int max_gap, input bit poke_start);
        int gap;
        @(negedge clk);
        start = 1'b1;
        for (int i = 0; i < num_rows; i++) begin
            gap = $unsigned($random(seed)) % (max_gap + 1);
            repeat (gap) begin
                @(negedge clk);
                start    = 1'b0;
                in_valid = 1'b0;
            end
            @(negedge clk);
            in_valid = 1'b1;
            in_data  = mat[i];
            start    = poke_start && (i == num_rows / 2);
        end
        last_accept_cyc = cyc + 1;
        for (int k = 0; k < num_blocks; k++) begin
            exp_k.push_back(k);
            exp_data.push_back(expected_block(k));
        end
        @(negedge clk);
        start    = 1'b0;
        in_valid = 1'b0;
        in_data  = '0;
        check_value("busy while draining", busy, 1);
    endtask

    task automatic wait_idle();
        int n;
        @(negedge clk);
        for (n = 0; busy && n < 100; n++) begin
            @(negedge clk);
        end
        assert (!busy) else begin
            $display("The buffer stayed busy and never finished its scan");
            stop_with_failure();
        end
    endtask

    task automatic test_reset_state();
        check_value("busy after reset", busy, 0);
        check_value("block_valid after reset", block_valid, 0);
        check_value("markers after reset", {slice_done, slice_last, buffer_done}, 0);
    endtask

    task automatic test_counting_pattern();
        int n;
        int base_blocks;
        base_blocks = block_count;
        fill_counting();
        load_matrix(0, 1'b0);
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!block_valid && n < 10);
        check_value("first block cycle", cyc, last_accept_cyc + 4);
        repeat (num_blocks - 1) begin
            @(negedge clk);
            check_value("block_valid run", block_valid, 1);
        end
        @(negedge clk);
        check_value("block_valid after run", block_valid, 0);
        wait_idle();
        check_value("blocks in counting test", block_count - base_blocks, num_blocks);
    endtask

    task automatic test_gapped_loading();
        int base_blocks;
        base_blocks = block_count;
        fill_random();
        load_matrix(3, 1'b0);
        wait_idle();
        check_value("blocks in gapped test", block_count - base_blocks, num_blocks);
    endtask

    task automatic test_ignored_strobes();
        int base_blocks;
        int base_buffers;
        base_blocks  = block_count;
        base_buffers = buffer_count;
        fill_random();
        // Rows offered while idle
        repeat (3) begin
            @(negedge clk);
            in_valid = 1'b1;
            in_data  = ~mat[0];
        end
        @(negedge clk);
        in_valid = 1'b0;
        load_matrix(1, 1'b1);
        // Start and a stray row during the scan
        @(negedge clk);
        start    = 1'b1;
        in_valid = 1'b1;
        in_data  = ~mat[1];
        @(negedge clk);
        start    = 1'b0;
        in_valid = 1'b0;
        wait_idle();
        check_value("blocks in strobe test", block_count - base_blocks, num_blocks);
        check_value("buffers in strobe test", buffer_count - base_buffers, 1);
    endtask

    task automatic test_back_to_back();
        int base_blocks;
        int base_buffers;
        base_blocks  = block_count;
        base_buffers = buffer_count;
        fill_random();
        load_matrix(0, 1'b0);
        wait_idle();
        fill_random();
        load_matrix(2, 1'b0);
        wait_idle();
        check_value("blocks in two buffers", block_count - base_blocks, 2 * num_blocks);
        check_value("buffer_done count", buffer_count - base_buffers, 2);
    endtask

    initial begin
        rst_n    = 1'b0;
        start    = 1'b0;
        in_valid = 1'b0;
        in_data  = '0;
        repeat (reset_cycles) @(negedge clk);
        rst_n = 1'b1;
        test_reset_state();
        test_counting_pattern();
        test_gapped_loading();
        test_ignored_strobes();
        test_back_to_back();
        check_value("blocks left pending", exp_k.size(), 0);
        check_value("total buffers", buffer_count, num_buffers);
        if (fail_count == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            stop_with_failure();
        end
    end

    initial begin
        repeat (num_buffers * 40 + reset_cycles + margin_cycles) @(posedge clk);
        $display("The run timed out before all tests finished");
        stop_with_failure();
    end

endmodule
